/* hw/glb_params.svh */
//////////////////////////////////////////////////
// global buffer bank widths
// byte address, data word and word address sizes
// configuration port widths
//////////////////////////////////////////////////

`ifndef GLB_PARAMS_SVH
`define GLB_PARAMS_SVH

// byte address of one bank, 4 KB
`define GLB_BANK_ADDR_WIDTH 12

// one bank word
`define GLB_BANK_DATA_WIDTH 64

// low address bits that select a byte inside the word
`define GLB_BANK_BYTE_OFFSET 3

// 512 words per bank
`define GLB_WORD_ADDR_WIDTH (`GLB_BANK_ADDR_WIDTH - `GLB_BANK_BYTE_OFFSET)

// configuration register port
`define GLB_CFG_ADDR_WIDTH 4
`define GLB_CFG_DATA_WIDTH 32

`endif

/* hw/glb_bank_pkg.sv */
//////////////////////////////////////////////////
// bank access types
// byte address, data word, word address
// memory port owner encoding
//////////////////////////////////////////////////

`default_nettype none

`include "glb_params.svh"

package glb_bank_pkg;

    // address as seen by the masters, byte granular
    typedef logic [`GLB_BANK_ADDR_WIDTH-1:0] bank_addr_t;

    // full bank word, also used for per-bit write select
    typedef logic [`GLB_BANK_DATA_WIDTH-1:0] bank_data_t;

    // address as seen by the sram
    typedef logic [`GLB_WORD_ADDR_WIDTH-1:0] word_addr_t;

    // which master owns the memory port
    typedef enum logic [1:0] {
        SRC_NONE = 2'd0,
        SRC_HOST = 2'd1,
        SRC_CGRA = 2'd2
    } access_src_t;

endpackage

`default_nettype wire

/* hw/glb_cfg_pkg.sv */
//////////////////////////////////////////////////
// configuration register map
// register offsets and data word type
//////////////////////////////////////////////////

`default_nettype none

`include "glb_params.svh"

package glb_cfg_pkg;

    // register offsets on the cfg port
    typedef enum logic [`GLB_CFG_ADDR_WIDTH-1:0] {
        // lowest word address cgra may write
        CFG_WIN_LO   = 4'd0,
        // highest word address cgra may write
        CFG_WIN_HI   = 4'd1,
        // dropped cgra strobes, write clears
        CFG_DROP_CNT = 4'd2
    } cfg_reg_e;

    // one configuration data word
    typedef logic [`GLB_CFG_DATA_WIDTH-1:0] cfg_data_t;

endpackage

`default_nettype wire

/* hw/glb_sram_model.sv */
//////////////////////////////////////////////////
// behavioral single-port sram
// per-bit write select
// one-cycle registered read
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "glb_params.svh"

module glb_sram_model import glb_bank_pkg::*; (
    input  logic        clk,
    input  logic        cen,
    input  logic        wen,
    input  word_addr_t  addr,
    input  bank_data_t  data_in,
    input  bank_data_t  bit_sel,
    output bank_data_t  data_out
);

    localparam int DEPTH = 1 << `GLB_WORD_ADDR_WIDTH;

    bank_data_t mem [0:DEPTH-1];

    // write merges only selected bits
    always_ff @(posedge clk) begin
        if (cen && wen) begin
            mem[addr] <= (mem[addr] & ~bit_sel) | (data_in & bit_sel);
        end
    end

    // read port, output stays until next read
    always_ff @(posedge clk) begin
        if (cen && !wen) begin
            data_out <= mem[addr];
        end
    end

endmodule

`default_nettype wire

/* hw/glb_sram_controller.sv */
//////////////////////////////////////////////////
// sram controller
// byte to word address, sram strobes
// read data select and hold
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "glb_params.svh"

module glb_sram_controller import glb_bank_pkg::*; (
    input  logic        clk,
    input  logic        reset,

    // from bank controller
    input  logic        ren,
    input  logic        wen,
    input  bank_addr_t  addr,
    input  bank_data_t  data_in,
    input  bank_data_t  data_in_bit_sel,
    output bank_data_t  data_out,

    // sram side
    output logic        sram_to_mem_cen,
    output logic        sram_to_mem_wen,
    output word_addr_t  sram_to_mem_addr,
    output bank_data_t  sram_to_mem_data,
    output bank_data_t  sram_to_mem_bit_sel,
    input  bank_data_t  mem_to_sram_data
);

    logic       ren_q;
    bank_data_t data_out_hold;

    // chip enable on any access
    assign sram_to_mem_cen     = ren | wen;
    assign sram_to_mem_wen     = wen;
    // drop byte offset
    assign sram_to_mem_addr    = addr[`GLB_BANK_BYTE_OFFSET +: `GLB_WORD_ADDR_WIDTH];
    assign sram_to_mem_data    = data_in;
    assign sram_to_mem_bit_sel = data_in_bit_sel;

    // sram output is fresh one cycle after ren
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ren_q         <= 1'b0;
            data_out_hold <= '0;
        end else begin
            ren_q         <= ren;
            data_out_hold <= data_out;
        end
    end

    // otherwise keep the last word
    assign data_out = ren_q ? mem_to_sram_data : data_out_hold;

endmodule

`default_nettype wire

/* hw/glb_bank_cfg_regs.sv */
//////////////////////////////////////////////////
// bank configuration registers
// cgra write window bounds
// saturating drop counter, cleared by write
// registered read port
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "glb_params.svh"

module glb_bank_cfg_regs import glb_bank_pkg::*, glb_cfg_pkg::*; (
    input  logic                           clk,
    input  logic                           reset,

    // cfg port
    input  logic                           cfg_wr_en,
    input  logic                           cfg_rd_en,
    input  logic [`GLB_CFG_ADDR_WIDTH-1:0] cfg_addr,
    input  cfg_data_t                      cfg_wr_data,
    output cfg_data_t                      cfg_rd_data,
    output logic                           cfg_rd_valid,

    // from controller
    input  logic [1:0]                     cgra_drop,

    // to controller
    output word_addr_t                     win_lo,
    output word_addr_t                     win_hi
);

    cfg_data_t                     drop_cnt;
    logic [`GLB_CFG_DATA_WIDTH:0]  drop_sum;

    // one extra bit to catch overflow
    assign drop_sum = {1'b0, drop_cnt} + {{(`GLB_CFG_DATA_WIDTH-1){1'b0}}, cgra_drop};

    // window bounds, full range after reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            win_lo <= '0;
            win_hi <= '1;
        end else if (cfg_wr_en) begin
            if (cfg_addr == CFG_WIN_LO) begin
                win_lo <= cfg_wr_data[`GLB_WORD_ADDR_WIDTH-1:0];
            end
            if (cfg_addr == CFG_WIN_HI) begin
                win_hi <= cfg_wr_data[`GLB_WORD_ADDR_WIDTH-1:0];
            end
        end
    end

    // drop counter
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            drop_cnt <= '0;
        end else if (cfg_wr_en && (cfg_addr == CFG_DROP_CNT)) begin
            // clear beats a drop in the same cycle
            drop_cnt <= '0;
        end else if (drop_sum[`GLB_CFG_DATA_WIDTH]) begin
            drop_cnt <= '1;
        end else begin
            drop_cnt <= drop_sum[`GLB_CFG_DATA_WIDTH-1:0];
        end
    end

    // read mux, registered
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_rd_valid <= 1'b0;
            cfg_rd_data  <= '0;
        end else begin
            cfg_rd_valid <= cfg_rd_en;
            if (cfg_rd_en) begin
                case (cfg_addr)
                    CFG_WIN_LO:   cfg_rd_data <= cfg_data_t'(win_lo);
                    CFG_WIN_HI:   cfg_rd_data <= cfg_data_t'(win_hi);
                    CFG_DROP_CNT: cfg_rd_data <= drop_cnt;
                    // unmapped offsets read as zero
                    default:      cfg_rd_data <= '0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* hw/glb_bank_cfg_controller.sv */
//////////////////////////////////////////////////
// bank controller
// host / cgra arbitration onto one memory port
// cgra write window and drop report
// per-master read data hold and valid
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "glb_params.svh"

module glb_bank_cfg_controller import glb_bank_pkg::*; (
    input  logic        clk,
    input  logic        reset,

    // host side
    input  logic        host_wr_en,
    input  bank_addr_t  host_wr_addr,
    input  bank_data_t  host_wr_data,
    input  bank_data_t  host_wr_data_bit_sel,
    input  logic        host_rd_en,
    input  bank_addr_t  host_rd_addr,
    output bank_data_t  host_rd_data,
    output logic        host_rd_valid,

    // cgra side
    input  logic        cgra_wr_en,
    input  bank_addr_t  cgra_wr_addr,
    input  bank_data_t  cgra_wr_data,
    input  bank_data_t  cgra_wr_data_bit_sel,
    input  logic        cgra_rd_en,
    input  bank_addr_t  cgra_rd_addr,
    output bank_data_t  cgra_rd_data,
    output logic        cgra_rd_valid,

    // from config regs
    input  word_addr_t  win_lo,
    input  word_addr_t  win_hi,
    output logic [1:0]  cgra_drop,

    // memory port
    output logic        mem_rd_en,
    output logic        mem_wr_en,
    output bank_addr_t  mem_addr,
    output bank_data_t  mem_data_in,
    output bank_data_t  mem_data_in_bit_sel,
    input  bank_data_t  mem_data_out
);

    logic        host_busy;
    word_addr_t  cgra_wr_word;
    logic        cgra_wr_in_win;
    logic        cgra_wr_drop;
    logic        cgra_rd_drop;
    access_src_t rd_src_d;
    access_src_t rd_src_q;
    bank_data_t  host_rd_hold;
    bank_data_t  cgra_rd_hold;

    // any host strobe takes the port
    assign host_busy = host_wr_en | host_rd_en;

    // window compare is on word addresses, bounds inclusive
    assign cgra_wr_word   = cgra_wr_addr[`GLB_BANK_BYTE_OFFSET +: `GLB_WORD_ADDR_WIDTH];
    assign cgra_wr_in_win = (cgra_wr_word >= win_lo) && (cgra_wr_word <= win_hi);

    // write lost to host or outside window
    assign cgra_wr_drop = cgra_wr_en & (host_busy | ~cgra_wr_in_win);
    // read lost to host or to an accepted cgra write
    assign cgra_rd_drop = cgra_rd_en & (host_busy | (cgra_wr_en & cgra_wr_in_win));
    // 0..2 drops per cycle
    assign cgra_drop = {1'b0, cgra_wr_drop} + {1'b0, cgra_rd_drop};

    // fixed priority select
    always_comb begin
        mem_wr_en           = 1'b0;
        mem_rd_en           = 1'b0;
        mem_addr            = '0;
        mem_data_in         = '0;
        mem_data_in_bit_sel = '0;
        rd_src_d            = SRC_NONE;
        if (host_wr_en) begin
            mem_wr_en           = 1'b1;
            mem_addr            = host_wr_addr;
            mem_data_in         = host_wr_data;
            mem_data_in_bit_sel = host_wr_data_bit_sel;
        end else if (host_rd_en) begin
            mem_rd_en = 1'b1;
            mem_addr  = host_rd_addr;
            rd_src_d  = SRC_HOST;
        end else if (cgra_wr_en && cgra_wr_in_win) begin
            mem_wr_en           = 1'b1;
            mem_addr            = cgra_wr_addr;
            mem_data_in         = cgra_wr_data;
            mem_data_in_bit_sel = cgra_wr_data_bit_sel;
        end else if (cgra_rd_en) begin
            mem_rd_en = 1'b1;
            mem_addr  = cgra_rd_addr;
            rd_src_d  = SRC_CGRA;
        end
    end

    // read owner one cycle behind, plus per-master holds
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_src_q     <= SRC_NONE;
            host_rd_hold <= '0;
            cgra_rd_hold <= '0;
        end else begin
            rd_src_q     <= rd_src_d;
            host_rd_hold <= host_rd_data;
            cgra_rd_hold <= cgra_rd_data;
        end
    end

    // returning word goes to the owner, the other master keeps its hold
    assign host_rd_valid = (rd_src_q == SRC_HOST);
    assign cgra_rd_valid = (rd_src_q == SRC_CGRA);
    assign host_rd_data  = host_rd_valid ? mem_data_out : host_rd_hold;
    assign cgra_rd_data  = cgra_rd_valid ? mem_data_out : cgra_rd_hold;

endmodule

`default_nettype wire

/* hw/glb_bank.sv */
//////////////////////////////////////////////////
// global buffer bank top
// controller, config regs, sram controller, sram
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "glb_params.svh"

module glb_bank import glb_bank_pkg::*, glb_cfg_pkg::*; (
    input  logic                           clk,
    input  logic                           reset,

    // host
    input  logic                           host_wr_en,
    input  bank_addr_t                     host_wr_addr,
    input  bank_data_t                     host_wr_data,
    input  bank_data_t                     host_wr_data_bit_sel,
    input  logic                           host_rd_en,
    input  bank_addr_t                     host_rd_addr,
    output bank_data_t                     host_rd_data,
    output logic                           host_rd_valid,

    // cgra
    input  logic                           cgra_wr_en,
    input  bank_addr_t                     cgra_wr_addr,
    input  bank_data_t                     cgra_wr_data,
    input  bank_data_t                     cgra_wr_data_bit_sel,
    input  logic                           cgra_rd_en,
    input  bank_addr_t                     cgra_rd_addr,
    output bank_data_t                     cgra_rd_data,
    output logic                           cgra_rd_valid,

    // configuration
    input  logic                           cfg_wr_en,
    input  logic                           cfg_rd_en,
    input  logic [`GLB_CFG_ADDR_WIDTH-1:0] cfg_addr,
    input  cfg_data_t                      cfg_wr_data,
    output cfg_data_t                      cfg_rd_data,
    output logic                           cfg_rd_valid
);

    // controller to regs
    word_addr_t win_lo;
    word_addr_t win_hi;
    logic [1:0] cgra_drop;

    // controller to sram controller
    logic       mem_rd_en;
    logic       mem_wr_en;
    bank_addr_t mem_addr;
    bank_data_t mem_data_in;
    bank_data_t mem_data_in_bit_sel;
    bank_data_t mem_data_out;

    // sram controller to sram
    logic       sram_cen;
    logic       sram_wen;
    word_addr_t sram_addr;
    bank_data_t sram_data_in;
    bank_data_t sram_bit_sel;
    bank_data_t sram_data_out;

    glb_bank_cfg_controller ctrl_i (
        .clk                  (clk),
        .reset                (reset),
        .host_wr_en           (host_wr_en),
        .host_wr_addr         (host_wr_addr),
        .host_wr_data         (host_wr_data),
        .host_wr_data_bit_sel (host_wr_data_bit_sel),
        .host_rd_en           (host_rd_en),
        .host_rd_addr         (host_rd_addr),
        .host_rd_data         (host_rd_data),
        .host_rd_valid        (host_rd_valid),
        .cgra_wr_en           (cgra_wr_en),
        .cgra_wr_addr         (cgra_wr_addr),
        .cgra_wr_data         (cgra_wr_data),
        .cgra_wr_data_bit_sel (cgra_wr_data_bit_sel),
        .cgra_rd_en           (cgra_rd_en),
        .cgra_rd_addr         (cgra_rd_addr),
        .cgra_rd_data         (cgra_rd_data),
        .cgra_rd_valid        (cgra_rd_valid),
        .win_lo               (win_lo),
        .win_hi               (win_hi),
        .cgra_drop            (cgra_drop),
        .mem_rd_en            (mem_rd_en),
        .mem_wr_en            (mem_wr_en),
        .mem_addr             (mem_addr),
        .mem_data_in          (mem_data_in),
        .mem_data_in_bit_sel  (mem_data_in_bit_sel),
        .mem_data_out         (mem_data_out)
    );

    glb_bank_cfg_regs regs_i (
        .clk          (clk),
        .reset        (reset),
        .cfg_wr_en    (cfg_wr_en),
        .cfg_rd_en    (cfg_rd_en),
        .cfg_addr     (cfg_addr),
        .cfg_wr_data  (cfg_wr_data),
        .cfg_rd_data  (cfg_rd_data),
        .cfg_rd_valid (cfg_rd_valid),
        .cgra_drop    (cgra_drop),
        .win_lo       (win_lo),
        .win_hi       (win_hi)
    );

    glb_sram_controller sram_ctrl_i (
        .clk                 (clk),
        .reset               (reset),
        .ren                 (mem_rd_en),
        .wen                 (mem_wr_en),
        .addr                (mem_addr),
        .data_in             (mem_data_in),
        .data_in_bit_sel     (mem_data_in_bit_sel),
        .data_out            (mem_data_out),
        .sram_to_mem_cen     (sram_cen),
        .sram_to_mem_wen     (sram_wen),
        .sram_to_mem_addr    (sram_addr),
        .sram_to_mem_data    (sram_data_in),
        .sram_to_mem_bit_sel (sram_bit_sel),
        .mem_to_sram_data    (sram_data_out)
    );

    glb_sram_model sram_i (
        .clk      (clk),
        .cen      (sram_cen),
        .wen      (sram_wen),
        .addr     (sram_addr),
        .data_in  (sram_data_in),
        .bit_sel  (sram_bit_sel),
        .data_out (sram_data_out)
    );

endmodule

`default_nettype wire

/* verif/glb_clk_gen.sv */
//////////////////////////////////////////////////
// testbench clock and reset
// 10 ns clock, reset held for two cycles
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module glb_clk_gen (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD = 5;

    // free running clock
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset high over the first two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

/* verif/glb_bank_tb.sv */
//////////////////////////////////////////////////
// global buffer bank testbench
// stimulus table applied one step at a time
// reference memory, window and drop count model
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "glb_params.svh"

module glb_bank_tb import glb_bank_pkg::*, glb_cfg_pkg::*; ();

    localparam int TIMEOUT = 20;

    // operation mask bits of a table step
    localparam logic [5:0] OP_HW = 6'b00_0001;
    localparam logic [5:0] OP_HR = 6'b00_0010;
    localparam logic [5:0] OP_CW = 6'b00_0100;
    localparam logic [5:0] OP_CR = 6'b00_1000;
    localparam logic [5:0] OP_FW = 6'b01_0000;
    localparam logic [5:0] OP_FR = 6'b10_0000;
    localparam bank_data_t ALL   = '1;

    logic                           clk;
    logic                           reset;
    logic                           host_wr_en;
    bank_addr_t                     host_wr_addr;
    bank_data_t                     host_wr_data;
    bank_data_t                     host_wr_data_bit_sel;
    logic                           host_rd_en;
    bank_addr_t                     host_rd_addr;
    bank_data_t                     host_rd_data;
    logic                           host_rd_valid;
    logic                           cgra_wr_en;
    bank_addr_t                     cgra_wr_addr;
    bank_data_t                     cgra_wr_data;
    bank_data_t                     cgra_wr_data_bit_sel;
    logic                           cgra_rd_en;
    bank_addr_t                     cgra_rd_addr;
    bank_data_t                     cgra_rd_data;
    logic                           cgra_rd_valid;
    logic                           cfg_wr_en;
    logic                           cfg_rd_en;
    logic [`GLB_CFG_ADDR_WIDTH-1:0] cfg_addr;
    cfg_data_t                      cfg_wr_data;
    cfg_data_t                      cfg_rd_data;
    logic                           cfg_rd_valid;

    // stimulus table, one entry per step
    logic [5:0]                     op_q[$];
    bank_addr_t                     haddr_q[$];
    bank_addr_t                     caddr_q[$];
    logic [`GLB_CFG_ADDR_WIDTH-1:0] faddr_q[$];
    cfg_data_t                      fdata_q[$];
    bank_data_t                     sel_q[$];
    string                          name_q[$];

    // reference state
    bank_data_t ref_mem [0:(1 << `GLB_WORD_ADDR_WIDTH)-1];
    word_addr_t win_lo_m;
    word_addr_t win_hi_m;
    cfg_data_t  drop_m;
    bank_data_t host_last;
    bank_data_t cgra_last;
    integer     seed;

    glb_clk_gen clk_gen_i (
        .clk   (clk),
        .reset (reset)
    );

    glb_bank dut_i (.*);

    task automatic add_step(input logic [5:0] ops, input bank_addr_t haddr,
                            input bank_addr_t caddr, input logic [3:0] faddr,
                            input cfg_data_t fdata, input bank_data_t sel, input string name);
        op_q.push_back(ops);
        haddr_q.push_back(haddr);
        caddr_q.push_back(caddr);
        faddr_q.push_back(faddr);
        fdata_q.push_back(fdata);
        sel_q.push_back(sel);
        name_q.push_back(name);
    endtask

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input bank_data_t exp, input bank_data_t act);
        if (exp !== act) begin
            stop_run($sformatf("ERROR: %s expected %h actual %h", name, exp, act));
        end
    endtask

    // bit select merge, only selected bits change
    function automatic bank_data_t merge_bits(bank_data_t cur, bank_data_t wdata,
                                              bank_data_t sel);
        bank_data_t res;
        res = cur;
        for (int b = 0; b < `GLB_BANK_DATA_WIDTH; b++) begin
            if (sel[b]) begin
                res[b] = wdata[b];
            end
        end
        return res;
    endfunction

    task automatic drive_idle();
        host_wr_en           <= 1'b0;
        host_wr_addr         <= '0;
        host_wr_data         <= '0;
        host_wr_data_bit_sel <= '0;
        host_rd_en           <= 1'b0;
        host_rd_addr         <= '0;
        cgra_wr_en           <= 1'b0;
        cgra_wr_addr         <= '0;
        cgra_wr_data         <= '0;
        cgra_wr_data_bit_sel <= '0;
        cgra_rd_en           <= 1'b0;
        cgra_rd_addr         <= '0;
        cfg_wr_en            <= 1'b0;
        cfg_rd_en            <= 1'b0;
        cfg_addr             <= '0;
        cfg_wr_data          <= '0;
    endtask

    task automatic build_table();
        // reset state of the config port
        add_step(OP_FR, 12'h000, 12'h000, CFG_WIN_LO, 32'd0, '0, "rst_win_lo");
        add_step(OP_FR, 12'h000, 12'h000, CFG_WIN_HI, 32'd0, '0, "rst_win_hi");
        add_step(OP_FR, 12'h000, 12'h000, CFG_DROP_CNT, 32'd0, '0, "rst_drop_cnt");
        add_step(OP_FR, 12'h000, 12'h000, 4'd5, 32'd0, '0, "cfg_unmapped");
        // plain write then read, each master
        add_step(OP_HW, 12'h010, 12'h000, 4'd0, 32'd0, ALL, "host_wr");
        add_step(OP_HR, 12'h010, 12'h000, 4'd0, 32'd0, '0, "host_rd");
        add_step(OP_CW, 12'h000, 12'h020, 4'd0, 32'd0, ALL, "cgra_wr");
        add_step(OP_CR, 12'h000, 12'h020, 4'd0, 32'd0, '0, "cgra_rd");
        add_step(OP_CR, 12'h000, 12'h013, 4'd0, 32'd0, '0, "cgra_rd_host_word");
        // partial writes
        add_step(OP_HW, 12'h010, 12'h000, 4'd0, 32'd0, 64'h0000_0000_ffff_0000, "host_part_wr");
        add_step(OP_HR, 12'h010, 12'h000, 4'd0, 32'd0, '0, "host_part_rd");
        add_step(OP_CW, 12'h000, 12'h020, 4'd0, 32'd0, 64'hff00_0000_0000_00ff, "cgra_part_wr");
        add_step(OP_CR, 12'h000, 12'h020, 4'd0, 32'd0, '0, "cgra_part_rd");
        // same cycle host and cgra
        add_step(OP_HW | OP_CW, 12'h030, 12'h020, 4'd0, 32'd0, ALL, "clash_wr_wr");
        add_step(OP_HR, 12'h030, 12'h000, 4'd0, 32'd0, '0, "clash_host_word");
        add_step(OP_HR, 12'h020, 12'h000, 4'd0, 32'd0, '0, "clash_cgra_word");
        add_step(OP_HR | OP_CR, 12'h010, 12'h020, 4'd0, 32'd0, '0, "clash_rd_rd");
        add_step(OP_FR, 12'h000, 12'h000, CFG_DROP_CNT, 32'd0, '0, "clash_drop_cnt");
        add_step(OP_CW | OP_CR, 12'h000, 12'h028, 4'd0, 32'd0, ALL, "cgra_wr_rd");
        add_step(OP_CR, 12'h000, 12'h028, 4'd0, 32'd0, '0, "cgra_wr_rd_chk");
        // narrow window to words 8..15
        add_step(OP_FW, 12'h000, 12'h000, CFG_WIN_LO, 32'd8, '0, "win_lo_wr");
        add_step(OP_FW, 12'h000, 12'h000, CFG_WIN_HI, 32'd15, '0, "win_hi_wr");
        add_step(OP_FR, 12'h000, 12'h000, CFG_WIN_LO, 32'd0, '0, "win_lo_rd");
        add_step(OP_FR, 12'h000, 12'h000, CFG_WIN_HI, 32'd0, '0, "win_hi_rd");
        add_step(OP_CW, 12'h000, 12'h010, 4'd0, 32'd0, ALL, "win_out_wr");
        add_step(OP_CR, 12'h000, 12'h010, 4'd0, 32'd0, '0, "win_out_rd");
        add_step(OP_CW, 12'h000, 12'h07d, 4'd0, 32'd0, ALL, "win_hi_edge_wr");
        add_step(OP_CR, 12'h000, 12'h078, 4'd0, 32'd0, '0, "win_hi_edge_rd");
        add_step(OP_CW, 12'h000, 12'h040, 4'd0, 32'd0, ALL, "win_lo_edge_wr");
        add_step(OP_HR, 12'h040, 12'h000, 4'd0, 32'd0, '0, "win_lo_edge_rd");
        add_step(OP_CW, 12'h000, 12'h080, 4'd0, 32'd0, ALL, "win_above_wr");
        add_step(OP_HW, 12'h080, 12'h000, 4'd0, 32'd0, ALL, "host_wr_outside");
        add_step(OP_HR, 12'h080, 12'h000, 4'd0, 32'd0, '0, "host_rd_outside");
        // drop counter read and clear
        add_step(OP_FR, 12'h000, 12'h000, CFG_DROP_CNT, 32'd0, '0, "drop_cnt_rd");
        add_step(OP_FW, 12'h000, 12'h000, CFG_DROP_CNT, 32'd0, '0, "drop_cnt_clr");
        add_step(OP_FR, 12'h000, 12'h000, CFG_DROP_CNT, 32'd0, '0, "drop_cnt_rd_clr");
    endtask

    task automatic run_step(input int i);
        logic [5:0]                     ops;
        bank_addr_t                     haddr;
        bank_addr_t                     caddr;
        logic [`GLB_CFG_ADDR_WIDTH-1:0] faddr;
        bank_data_t                     sel;
        string                          name;
        bank_data_t                     hdata;
        bank_data_t                     cdata;
        word_addr_t                     hword;
        word_addr_t                     cword;
        logic                           busy;
        logic                           in_win;
        logic                           exp_hr;
        logic                           exp_cr;
        cfg_data_t                      exp_cfg;
        int                             drops;
        int                             cycles;
        ops   = op_q[i];
        haddr = haddr_q[i];
        caddr = caddr_q[i];
        faddr = faddr_q[i];
        sel   = sel_q[i];
        name  = name_q[i];
        hdata = {$random(seed), $random(seed)};
        cdata = {$random(seed), $random(seed)};
        hword = haddr[`GLB_BANK_BYTE_OFFSET +: `GLB_WORD_ADDR_WIDTH];
        cword = caddr[`GLB_BANK_BYTE_OFFSET +: `GLB_WORD_ADDR_WIDTH];

        @(posedge clk);
        host_wr_en           <= ops[0];
        host_wr_addr         <= haddr;
        host_wr_data         <= hdata;
        host_wr_data_bit_sel <= sel;
        host_rd_en           <= ops[1];
        host_rd_addr         <= haddr;
        cgra_wr_en           <= ops[2];
        cgra_wr_addr         <= caddr;
        cgra_wr_data         <= cdata;
        cgra_wr_data_bit_sel <= sel;
        cgra_rd_en           <= ops[3];
        cgra_rd_addr         <= caddr;
        cfg_wr_en            <= ops[4];
        cfg_rd_en            <= ops[5];
        cfg_addr             <= faddr;
        cfg_wr_data          <= fdata_q[i];

        // host first, then cgra write in window, then cgra read
        busy   = ops[0] | ops[1];
        in_win = (cword >= win_lo_m) && (cword <= win_hi_m);
        exp_hr = ops[1] & ~ops[0];
        exp_cr = ops[3] & ~busy & ~(ops[2] & in_win);
        if (exp_hr) host_last = ref_mem[hword];
        if (exp_cr) cgra_last = ref_mem[cword];
        if (ops[0]) begin
            ref_mem[hword] = merge_bits(ref_mem[hword], hdata, sel);
        end else if (ops[2] && in_win && !busy) begin
            ref_mem[cword] = merge_bits(ref_mem[cword], cdata, sel);
        end
        drops = 0;
        if (ops[2] && (busy || !in_win)) drops++;
        if (ops[3] && !exp_cr) drops++;

        // cfg read sees the state before this step
        case (faddr)
            CFG_WIN_LO:   exp_cfg = cfg_data_t'(win_lo_m);
            CFG_WIN_HI:   exp_cfg = cfg_data_t'(win_hi_m);
            CFG_DROP_CNT: exp_cfg = drop_m;
            default:      exp_cfg = '0;
        endcase
        if (ops[4] && faddr == CFG_WIN_LO) win_lo_m = fdata_q[i][`GLB_WORD_ADDR_WIDTH-1:0];
        if (ops[4] && faddr == CFG_WIN_HI) win_hi_m = fdata_q[i][`GLB_WORD_ADDR_WIDTH-1:0];
        // clear wins over drops of the same cycle
        if (ops[4] && faddr == CFG_DROP_CNT) begin
            drop_m = '0;
        end else begin
            repeat (drops) begin
                if (drop_m != '1) drop_m = drop_m + 1;
            end
        end

        if (ops[1] | ops[3] | ops[5]) begin
            @(posedge clk);
            drive_idle();
            cycles = 0;
            @(negedge clk);
            if (exp_hr | exp_cr | ops[5]) begin
                while (!(host_rd_valid | cgra_rd_valid | cfg_rd_valid)) begin
                    if (cycles >= TIMEOUT) begin
                        stop_run($sformatf("timeout: no read valid in step %s", name));
                    end
                    @(negedge clk);
                    cycles++;
                end
            end
            // valid exactly one cycle after the strobe
            check_value({name, " extra cycles"}, 64'd0, bank_data_t'(cycles));
            check_value({name, " host valid"}, {63'b0, exp_hr}, {63'b0, host_rd_valid});
            check_value({name, " cgra valid"}, {63'b0, exp_cr}, {63'b0, cgra_rd_valid});
            check_value({name, " cfg valid"}, {63'b0, ops[5]}, {63'b0, cfg_rd_valid});
            if (exp_hr) check_value({name, " host data"}, host_last, host_rd_data);
            if (exp_cr) check_value({name, " cgra data"}, cgra_last, cgra_rd_data);
            if (ops[5]) check_value({name, " cfg data"}, {32'b0, exp_cfg}, {32'b0, cfg_rd_data});
            // both masters keep their last word
            @(negedge clk);
            check_value({name, " host hold"}, host_last, host_rd_data);
            check_value({name, " cgra hold"}, cgra_last, cgra_rd_data);
        end
    endtask

    initial begin
        int cycles;
        seed      = 32'h7c00_1bb9;
        win_lo_m  = '0;
        win_hi_m  = '1;
        drop_m    = '0;
        host_last = '0;
        cgra_last = '0;
        drive_idle();
        build_table();

        cycles = 0;
        @(negedge clk);
        while (reset) begin
            if (cycles >= TIMEOUT) stop_run("reset was never released");
            @(negedge clk);
            cycles++;
        end
        // holds and valids after reset
        check_value("reset host data", 64'd0, host_rd_data);
        check_value("reset cgra data", 64'd0, cgra_rd_data);
        check_value("reset host valid", 64'd0, {63'b0, host_rd_valid});
        check_value("reset cgra valid", 64'd0, {63'b0, cgra_rd_valid});

        for (int i = 0; i < op_q.size(); i++) begin
            run_step(i);
        end
        @(posedge clk);
        drive_idle();
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+hw
hw/glb_bank_pkg.sv
hw/glb_cfg_pkg.sv
hw/glb_sram_model.sv
hw/glb_sram_controller.sv
hw/glb_bank_cfg_regs.sv
hw/glb_bank_cfg_controller.sv
hw/glb_bank.sv
verif/glb_clk_gen.sv
verif/glb_bank_tb.sv

/* Makefile */
# Verilator build and run for the global buffer bank testbench

VERILATOR ?= verilator
TOP       ?= glb_bank_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
SIM       ?= $(BUILD_DIR)/V$(TOP)

SOURCES := $(FILELIST) $(wildcard hw/*.sv hw/*.svh verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
